// ==== source/conv_pkg.sv ====
package conv_pkg;

    // ------------------------------
    // array and bus sizes
    // ------------------------------
    localparam int NUM_ROWS       = 4;  // output channels
    localparam int NUM_COLS       = 8;  // input channels
    localparam int WORD_W         = 32; // shared bus width
    localparam int DATA_W         = 8;  // weight / ifmap operand
    localparam int PSUM_W         = 16; // partial sum
    localparam int BYTES_PER_WORD = WORD_W / DATA_W;
    localparam int WORDS_PER_ROW  = NUM_COLS / BYTES_PER_WORD; // weight words per row
    localparam int IFMAP_WORDS    = NUM_COLS / BYTES_PER_WORD;
    localparam int COMPUTE_CYCLES = 2;  // product stage, then result stage

    // ------------------------------
    // scalar types
    // ------------------------------
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [2:0]               row_cnt_t; // 1..4 active rows
    typedef logic [2:0]               idx_t;     // word index within a phase
    typedef logic signed [DATA_W-1:0] operand_t;
    typedef logic signed [PSUM_W-1:0] psum_t;

    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        IFMAP_LOAD,
        IPSUM_LOAD,
        COMPUTE,
        OPSUM_OUT
    } state_t;

    // ------------------------------
    // packed buses
    // ------------------------------
    typedef operand_t [NUM_ROWS-1:0][NUM_COLS-1:0] weight_grid_t;  // [row][col]
    typedef operand_t [NUM_COLS-1:0]               ifmap_vec_t;
    typedef psum_t    [NUM_ROWS-1:0][NUM_COLS-1:0] product_grid_t; // [row][col]
    typedef psum_t    [NUM_ROWS-1:0]               psum_vec_t;

    typedef struct packed {
        logic w_wr;     // weight word accepted
        logic if_wr;    // ifmap word accepted
        logic ip_wr;    // ipsum word accepted
        idx_t idx;      // word position in the phase
        logic mul_en;   // pe array captures products
        logic op_store; // opsum buffer captures sums
        logic op_shift; // opsum word consumed
    } buf_ctrl_t;

endpackage

// ==== source/weight_buffer.sv ====
`timescale 1ns/1ps

module weight_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  conv_pkg::buf_ctrl_t    ctrl,
    input  conv_pkg::word_t        data_in,
    output conv_pkg::weight_grid_t weights
);

    conv_pkg::weight_grid_t grid_q;
    logic [1:0]            row_sel;  // word 2r+h goes to row r
    logic                  half_sel; // column half h

    assign row_sel  = ctrl.idx[2:1];
    assign half_sel = ctrl.idx[0];

    // ------------------------------
    // word write, four bytes per word
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grid_q <= '0;
        end else if (ctrl.w_wr) begin
            for (int b = 0; b < conv_pkg::BYTES_PER_WORD; b++) begin
                // byte 0 lands in the lowest column of the half
                grid_q[row_sel][half_sel * conv_pkg::BYTES_PER_WORD + b] <=
                    conv_pkg::operand_t'(data_in[b*conv_pkg::DATA_W +: conv_pkg::DATA_W]);
            end
        end
    end

    // untouched rows keep last pass weights
    assign weights = grid_q;

endmodule

// ==== source/ifmap_buffer.sv ====
`timescale 1ns/1ps

module ifmap_buffer (
    input  logic                clk,
    input  logic                reset,
    input  conv_pkg::buf_ctrl_t  ctrl,
    input  conv_pkg::word_t      data_in,
    output conv_pkg::ifmap_vec_t ifmap
);

    conv_pkg::ifmap_vec_t vec_q;
    logic                half_sel; // word h covers cols 4h..4h+3

    assign half_sel = ctrl.idx[0];

    // ------------------------------
    // column fill
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            vec_q <= '0;
        end else if (ctrl.if_wr) begin
            for (int b = 0; b < conv_pkg::BYTES_PER_WORD; b++) begin
                vec_q[half_sel * conv_pkg::BYTES_PER_WORD + b] <=
                    conv_pkg::operand_t'(data_in[b*conv_pkg::DATA_W +: conv_pkg::DATA_W]);
            end
        end
    end

    // same vector broadcast down every row
    assign ifmap = vec_q;

endmodule

// ==== source/ipsum_buffer.sv ====
`timescale 1ns/1ps

module ipsum_buffer (
    input  logic               clk,
    input  logic               reset,
    input  conv_pkg::buf_ctrl_t ctrl,
    input  conv_pkg::word_t     data_in,
    output conv_pkg::psum_vec_t ipsum
);

    conv_pkg::psum_vec_t psum_q;
    logic [1:0]         row_sel; // word r is row r

    assign row_sel = ctrl.idx[1:0];

    // ------------------------------
    // one psum per accepted word
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            psum_q <= '0;
        else if (ctrl.ip_wr)
            psum_q[row_sel] <= conv_pkg::psum_t'(data_in[conv_pkg::PSUM_W-1:0]); // upper half dropped
    end

    // rows past row_en stay stale, never unloaded
    assign ipsum = psum_q;

endmodule

// ==== source/pe_array.sv ====
`timescale 1ns/1ps

module pe_array (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mul_en,
    input  conv_pkg::weight_grid_t  weights,
    input  conv_pkg::ifmap_vec_t    ifmap,
    output conv_pkg::product_grid_t products
);

    conv_pkg::product_grid_t prod_q;
    conv_pkg::product_grid_t prod_d; // combinational multipliers

    // ------------------------------
    // multiplier grid
    // ------------------------------
    always_comb begin
        for (int r = 0; r < conv_pkg::NUM_ROWS; r++) begin
            for (int c = 0; c < conv_pkg::NUM_COLS; c++) begin
                // 8x8 signed fits 16 bits, no wrap here
                prod_d[r][c] = $signed(weights[r][c]) * $signed(ifmap[c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            prod_q <= '0;
        else if (mul_en)
            prod_q <= prod_d; // held until next compute
    end

    assign products = prod_q;

endmodule

// ==== source/reducer.sv ====
`timescale 1ns/1ps

module reducer (
    input  conv_pkg::product_grid_t products,
    input  conv_pkg::psum_vec_t     ipsum,
    output conv_pkg::psum_vec_t     sums
);

    // ------------------------------
    // per row tree, 8 -> 4 -> 2 -> 1
    // ------------------------------
    always_comb begin
        conv_pkg::psum_t lvl1 [4];
        conv_pkg::psum_t lvl2 [2];
        conv_pkg::psum_t tree;
        for (int r = 0; r < conv_pkg::NUM_ROWS; r++) begin
            for (int i = 0; i < 4; i++)
                lvl1[i] = products[r][2*i] + products[r][2*i+1]; // adjacent columns
            for (int i = 0; i < 2; i++)
                lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
            tree    = lvl2[0] + lvl2[1];
            sums[r] = tree + ipsum[r]; // 16 bit wrap
        end
    end

endmodule

// ==== source/opsum_buffer.sv ====
`timescale 1ns/1ps

module opsum_buffer (
    input  logic               clk,
    input  logic               reset,
    input  conv_pkg::buf_ctrl_t ctrl,
    input  conv_pkg::psum_vec_t sums,
    input  logic               valid_op,
    output conv_pkg::word_t     data_out
);

    conv_pkg::psum_vec_t row_q; // row 0 is the head

    // ------------------------------
    // capture and shift out
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            row_q <= '0;
        end else if (ctrl.op_store) begin
            row_q <= sums;                         // all rows at once
        end else if (ctrl.op_shift) begin
            for (int r = 0; r < conv_pkg::NUM_ROWS - 1; r++)
                row_q[r] <= row_q[r+1];            // next row to head
            row_q[conv_pkg::NUM_ROWS-1] <= '0;
        end
    end

    // head stays put under back-pressure
    always_comb begin
        if (valid_op)
            data_out = {{(conv_pkg::WORD_W - conv_pkg::PSUM_W){1'b0}}, row_q[0]}; // zero above
        else
            data_out = '0;
    end

endmodule

// ==== source/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid_w,
    input  logic                valid_if,
    input  logic                valid_ip,
    input  logic                ready_op,
    input  conv_pkg::row_cnt_t   row_en,
    output logic                ready_w,
    output logic                ready_if,
    output logic                ready_ip,
    output logic                valid_op,
    output conv_pkg::buf_ctrl_t  ctrl
);

    conv_pkg::state_t state_q;
    conv_pkg::state_t next_state;
    conv_pkg::idx_t   idx_q;      // words done in this phase
    conv_pkg::idx_t   last_idx;   // index of the final word of the phase
    logic            step;       // one unit of progress this cycle
    logic            phase_done; // final word of the phase completes

    // ------------------------------
    // handshake outputs
    // ------------------------------
    assign ready_w  = (state_q == conv_pkg::WEIGHT_LOAD); // straight from state
    assign ready_if = (state_q == conv_pkg::IFMAP_LOAD);
    assign ready_ip = (state_q == conv_pkg::IPSUM_LOAD);
    assign valid_op = (state_q == conv_pkg::OPSUM_OUT);

    // phase length from row_en
    always_comb begin
        case (state_q)
            conv_pkg::WEIGHT_LOAD: last_idx = conv_pkg::idx_t'(row_en * conv_pkg::WORDS_PER_ROW - 1);
            conv_pkg::IFMAP_LOAD:  last_idx = conv_pkg::idx_t'(conv_pkg::IFMAP_WORDS - 1);
            conv_pkg::IPSUM_LOAD:  last_idx = conv_pkg::idx_t'(row_en - 1); // one per row
            conv_pkg::COMPUTE:     last_idx = conv_pkg::idx_t'(conv_pkg::COMPUTE_CYCLES - 1);
            conv_pkg::OPSUM_OUT:   last_idx = conv_pkg::idx_t'(row_en - 1);
            default:              last_idx = '0;
        endcase
    end

    // a completed transfer, or a compute cycle
    always_comb begin
        case (state_q)
            conv_pkg::WEIGHT_LOAD: step = valid_w;
            conv_pkg::IFMAP_LOAD:  step = valid_if;
            conv_pkg::IPSUM_LOAD:  step = valid_ip;
            conv_pkg::COMPUTE:     step = 1'b1;     // fixed length
            conv_pkg::OPSUM_OUT:   step = ready_op;
            default:              step = 1'b0;
        endcase
    end

    assign phase_done = step && (idx_q == last_idx);

    // ------------------------------
    // pass FSM
    // ------------------------------
    always_comb begin
        next_state = state_q;
        case (state_q)
            conv_pkg::IDLE: begin
                if (valid_w)
                    next_state = conv_pkg::WEIGHT_LOAD;
                else if (valid_if)
                    next_state = conv_pkg::IFMAP_LOAD; // reuse stored weights
            end
            conv_pkg::WEIGHT_LOAD: if (phase_done) next_state = conv_pkg::IFMAP_LOAD;
            conv_pkg::IFMAP_LOAD:  if (phase_done) next_state = conv_pkg::IPSUM_LOAD;
            conv_pkg::IPSUM_LOAD:  if (phase_done) next_state = conv_pkg::COMPUTE;
            conv_pkg::COMPUTE:     if (phase_done) next_state = conv_pkg::OPSUM_OUT;
            conv_pkg::OPSUM_OUT:   if (phase_done) next_state = conv_pkg::IDLE;
            default:              next_state = conv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= conv_pkg::IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= next_state;
            if (phase_done)
                idx_q <= '0;          // restart for next phase
            else if (step)
                idx_q <= idx_q + 3'd1;
        end
    end

    // ------------------------------
    // buffer strobes
    // ------------------------------
    always_comb begin
        ctrl          = '0;
        ctrl.idx      = idx_q;                                    // word being written
        ctrl.w_wr     = (state_q == conv_pkg::WEIGHT_LOAD) && valid_w;
        ctrl.if_wr    = (state_q == conv_pkg::IFMAP_LOAD) && valid_if;
        ctrl.ip_wr    = (state_q == conv_pkg::IPSUM_LOAD) && valid_ip;
        ctrl.mul_en   = (state_q == conv_pkg::COMPUTE) && (idx_q == '0); // first cycle
        ctrl.op_store = (state_q == conv_pkg::COMPUTE) && phase_done;     // second cycle
        ctrl.op_shift = (state_q == conv_pkg::OPSUM_OUT) && ready_op;
    end

endmodule

// ==== source/conv_unit.sv ====
`timescale 1ns/1ps

module conv_unit (
    input  logic              clk,
    input  logic              reset,
    input  conv_pkg::word_t    data_in,
    input  logic              valid_w,
    input  logic              valid_if,
    input  logic              valid_ip,
    input  logic              ready_op,
    input  conv_pkg::row_cnt_t row_en,    // active rows, held for the whole pass
    output conv_pkg::word_t    data_out,
    output logic              ready_w,
    output logic              ready_if,
    output logic              ready_ip,
    output logic              valid_op
);

    conv_pkg::buf_ctrl_t     ctrl;     // strobes from the FSM
    conv_pkg::weight_grid_t  weights;  // horizontal buffer contents
    conv_pkg::ifmap_vec_t    ifmap;    // vertical buffer contents
    conv_pkg::psum_vec_t     ipsum;    // one per row
    conv_pkg::product_grid_t products; // registered pe outputs
    conv_pkg::psum_vec_t     sums;     // reducer results

    // ------------------------------
    // control
    // ------------------------------
    conv_ctrl i_conv_ctrl (
        .clk      (clk),
        .reset    (reset),
        .valid_w  (valid_w),
        .valid_if (valid_if),
        .valid_ip (valid_ip),
        .ready_op (ready_op),
        .row_en   (row_en),
        .ready_w  (ready_w),
        .ready_if (ready_if),
        .ready_ip (ready_ip),
        .valid_op (valid_op),
        .ctrl     (ctrl)
    );

    // ------------------------------
    // input buffers
    // ------------------------------
    weight_buffer i_weight_buffer (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .data_in (data_in),
        .weights (weights)
    );

    ifmap_buffer i_ifmap_buffer (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .data_in (data_in),
        .ifmap   (ifmap)
    );

    ipsum_buffer i_ipsum_buffer (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .data_in (data_in),
        .ipsum   (ipsum)
    );

    // ------------------------------
    // datapath
    // ------------------------------
    pe_array i_pe_array (
        .clk      (clk),
        .reset    (reset),
        .mul_en   (ctrl.mul_en),
        .weights  (weights),
        .ifmap    (ifmap),
        .products (products)
    );

    reducer i_reducer (
        .products (products),
        .ipsum    (ipsum),
        .sums     (sums)
    );

    opsum_buffer i_opsum_buffer (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .sums     (sums),
        .valid_op (valid_op),
        .data_out (data_out)
    );

endmodule

// ==== testbench/conv_unit_props.sv ====
`timescale 1ns/1ps

module conv_unit_props (
    input logic            clk,
    input logic            reset,
    input logic            ready_w,
    input logic            ready_if,
    input logic            ready_ip,
    input logic            valid_op,
    input logic            ready_op,
    input conv_pkg::word_t data_out
);

    int fail_count = 0; // failed assertions so far

    // ------------------------------
    // handshake rules
    // ------------------------------
    a_one_phase: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ready_w, ready_if, ready_ip, valid_op}))
        else begin $error("more than one handshake output high"); fail_count++; end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !(ready_w || ready_if || ready_ip || valid_op))
        else begin $error("handshake output high after reset"); fail_count++; end

    a_hold_output: assert property (@(posedge clk) disable iff (reset)
        (valid_op && !ready_op) |=> (valid_op && $stable(data_out)))
        else begin $error("opsum dropped or changed under stall"); fail_count++; end

endmodule

bind conv_unit conv_unit_props i_conv_unit_props (.*);

// ==== testbench/conv_unit_tb.sv ====
`timescale 1ns/1ps

module conv_unit_tb;

    localparam int MAX_CYCLES = 6000; // 20 passes x 150 cycles, doubled

    logic               clk;
    logic               reset;
    conv_pkg::word_t    data_in;
    logic               valid_w;
    logic               valid_if;
    logic               valid_ip;
    logic               ready_op;
    conv_pkg::row_cnt_t row_en;
    conv_pkg::word_t    data_out;
    logic               ready_w;
    logic               ready_if;
    logic               ready_ip;
    logic               valid_op;

    integer seed = 3;
    int     cycles = 0;

    conv_pkg::operand_t w_model [conv_pkg::NUM_ROWS][conv_pkg::NUM_COLS]; // mirrors weight grid
    conv_pkg::operand_t x_model [conv_pkg::NUM_COLS];
    conv_pkg::psum_t    ip_model [conv_pkg::NUM_ROWS];

    conv_unit i_conv_unit (
        .clk(clk), .reset(reset), .data_in(data_in),
        .valid_w(valid_w), .valid_if(valid_if), .valid_ip(valid_ip),
        .ready_op(ready_op), .row_en(row_en), .data_out(data_out),
        .ready_w(ready_w), .ready_if(ready_if), .ready_ip(ready_ip), .valid_op(valid_op)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    always @(posedge clk) begin
        cycles++;
        if (i_conv_unit.i_conv_unit_props.fail_count != 0) begin
            $display("a handshake assertion failed at %0t", $time);
            $display("TB FAILED");
            $fatal(1, "assertion failed");
        end else if (cycles >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic fail(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_psum(input conv_pkg::psum_t got, input conv_pkg::psum_t exp,
                              input string what);
        if (got !== exp)
            fail($sformatf("%s: got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_state_outputs(input logic ew, input logic eif, input logic eip,
                                       input logic eop);
        if ({ready_w, ready_if, ready_ip, valid_op} !== {ew, eif, eip, eop})
            fail($sformatf("handshake outputs %b expected %b",
                           {ready_w, ready_if, ready_ip, valid_op}, {ew, eif, eip, eop}));
        if (!eop && data_out !== '0)
            fail("data_out not zero outside opsum phase");
    endtask

    // ------------------------------
    // reference model and data
    // ------------------------------
    function automatic conv_pkg::psum_t ref_sum(input int r);
        int acc;
        acc = ip_model[r];
        for (int c = 0; c < conv_pkg::NUM_COLS; c++)
            acc += w_model[r][c] * x_model[c]; // full precision, wrap at the end
        return conv_pkg::psum_t'(acc);
    endfunction

    function automatic conv_pkg::operand_t rand_operand();
        int pick;
        pick = $unsigned($random(seed)) % 8;
        if (pick == 0)
            return -8'sd128; // extremes now and then
        else if (pick == 1)
            return 8'sd127;
        return conv_pkg::operand_t'($random(seed));
    endfunction

    task automatic fill_data(input int rows, input bit load_w);
        for (int r = 0; r < rows; r++) begin
            if (load_w)
                for (int c = 0; c < conv_pkg::NUM_COLS; c++)
                    w_model[r][c] = rand_operand();
            ip_model[r] = conv_pkg::psum_t'($random(seed));
        end
        for (int c = 0; c < conv_pkg::NUM_COLS; c++)
            x_model[c] = rand_operand();
    endtask

    // ------------------------------
    // handshake drivers
    // ------------------------------
    task automatic set_valid(input int ch, input logic v);
        case (ch)
            0: valid_w <= v;
            1: valid_if <= v;
            default: valid_ip <= v;
        endcase
    endtask

    function automatic logic ready_of(input int ch);
        return (ch == 0) ? ready_w : (ch == 1) ? ready_if : ready_ip;
    endfunction

    // entered right after a rising edge, returns after the accepting edge
    task automatic push_word(input int ch, input conv_pkg::word_t w, input bit gaps);
        int gap;
        gap = gaps ? $unsigned($random(seed)) % 4 : 0;
        repeat (gap) begin
            set_valid(ch, 1'b0); // sender pauses
            @(posedge clk);
        end
        set_valid(ch, 1'b1);
        data_in <= w;
        do @(negedge clk); while (!ready_of(ch)); // ready is settled mid-cycle
        @(posedge clk);
    endtask

    task automatic after_phase(input logic ew, input logic eif, input logic eip,
                               input logic eop);
        @(negedge clk);
        check_state_outputs(ew, eif, eip, eop); // also proves the word count
        @(posedge clk);
    endtask

    task automatic send_weights(input int rows, input bit gaps);
        conv_pkg::word_t w;
        for (int k = 0; k < 2 * rows; k++) begin
            for (int b = 0; b < conv_pkg::BYTES_PER_WORD; b++)
                w[b*8 +: 8] = w_model[k/2][4*(k%2) + b]; // word 2r+h, byte 0 lowest
            push_word(0, w, gaps);
        end
        valid_w <= 1'b0;
        after_phase(1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic send_ifmap(input bit gaps);
        conv_pkg::word_t w;
        for (int h = 0; h < 2; h++) begin
            for (int b = 0; b < conv_pkg::BYTES_PER_WORD; b++)
                w[b*8 +: 8] = x_model[4*h + b];
            push_word(1, w, gaps);
        end
        valid_if <= 1'b0;
        after_phase(1'b0, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic send_ipsum(input int rows, input bit gaps);
        for (int r = 0; r < rows; r++)
            push_word(2, {16'($random(seed)), ip_model[r]}, gaps); // junk upper half
        valid_ip <= 1'b0;
        after_phase(1'b0, 1'b0, 1'b0, 1'b0); // in compute
    endtask

    task automatic collect_opsum(input int rows, input bit stalls);
        bit got;
        for (int i = 0; i < rows; i++) begin
            got = 0;
            while (!got) begin
                ready_op <= stalls ? ($random(seed) % 2 != 0) : 1'b1;
                @(negedge clk);
                if (valid_op && ready_op) begin
                    check_psum(conv_pkg::psum_t'(data_out[15:0]), ref_sum(i),
                               $sformatf("opsum row %0d", i));
                    if (data_out[31:16] !== 16'h0)
                        fail($sformatf("opsum row %0d upper bits not zero", i));
                    got = 1;
                end
                @(posedge clk);
            end
        end
        ready_op <= 1'b0;
        after_phase(1'b0, 1'b0, 1'b0, 1'b0); // back in idle
    endtask

    task automatic run_pass(input bit load_w, input int rows, input bit gaps, input bit stalls);
        row_en <= conv_pkg::row_cnt_t'(rows); // stable for the whole pass
        if (load_w)
            send_weights(rows, gaps);
        send_ifmap(gaps);
        send_ipsum(rows, gaps);
        collect_opsum(rows, stalls);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_reset_and_counts();
        after_phase(1'b0, 1'b0, 1'b0, 1'b0);
        fill_data(2, 1);
        run_pass(1, 2, 0, 0);
    endtask

    task automatic test_hand_picked();
        for (int r = 0; r < conv_pkg::NUM_ROWS; r++) begin
            for (int c = 0; c < conv_pkg::NUM_COLS; c++)
                w_model[r][c] = conv_pkg::operand_t'((r + 1) * (c - 4));
            ip_model[r] = conv_pkg::psum_t'(100 * r - 150);
        end
        for (int c = 0; c < conv_pkg::NUM_COLS; c++)
            x_model[c] = conv_pkg::operand_t'(3 * c - 10);
        run_pass(1, 4, 0, 0);
    endtask

    task automatic test_weight_reuse();
        fill_data(4, 0); // new ifmap and ipsum only
        run_pass(0, 4, 0, 0);
    endtask

    task automatic test_backpressure();
        repeat (3) begin
            fill_data(4, 1);
            run_pass(1, 4, 1, 1);
        end
    endtask

    task automatic test_random_passes();
        int  rows;
        bit  load_w;
        for (int p = 0; p < 10; p++) begin
            rows   = 1 + $unsigned($random(seed)) % 4;
            load_w = (p == 0) || ($random(seed) % 2 != 0);
            fill_data(rows, load_w);
            if (p == 0) begin
                rows = 4;
                foreach (w_model[r, c])
                    w_model[r][c] = -8'sd128; // 8 x 16384 overflows 16 bits
                foreach (x_model[c])
                    x_model[c] = -8'sd128;
            end
            run_pass(load_w, rows, 1, 1);
        end
    endtask

    initial begin
        reset    = 1'b1;
        data_in  = '0;
        valid_w  = 1'b0;
        valid_if = 1'b0;
        valid_ip = 1'b0;
        ready_op = 1'b0;
        row_en   = 3'd4;
        foreach (w_model[r, c])
            w_model[r][c] = '0; // grid clears on reset
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        test_reset_and_counts();
        test_hand_picked();
        test_weight_reuse();
        test_backpressure();
        test_random_passes();
        if (i_conv_unit.i_conv_unit_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/conv_pkg.sv
source/weight_buffer.sv
source/ifmap_buffer.sv
source/ipsum_buffer.sv
source/pe_array.sv
source/reducer.sv
source/opsum_buffer.sv
source/conv_ctrl.sv
source/conv_unit.sv
testbench/conv_unit_props.sv
testbench/conv_unit_tb.sv
